/* hw/cred_req_pkg.sv */
// request-side types and sizes, referenced by scoped name from route, credits and arbiter
package cred_req_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int n_dests = 2;   // number of remote destinations
  localparam int dest_w  = 1;   // destination index width
  localparam int len_w   = 5;   // beat count, 1..16
  localparam int tag_w   = 8;   // request tag, passed through untouched
  // one bit wider than len so a full buffer's worth fits
  localparam int cred_w  = 6;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // write request, 14 bits
  typedef struct packed {
    logic [dest_w-1:0] dest;
    logic [len_w-1:0]  len;
    logic [tag_w-1:0]  tag;
  } req_t;

  // forwarding order for the data mux, 6 bits
  typedef struct packed {
    logic [dest_w-1:0] dest;
    logic [len_w-1:0]  len;
  } mux_user_t;

endpackage

/* hw/cred_axis_pkg.sv */
// stream beat type and buffer depths, referenced by scoped name from buffers, mux and top
package cred_axis_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int data_w      = 64;  // full word per beat, no keep
  // per-destination data buffer, also the largest legal len
  localparam int buf_depth   = 16;
  localparam int req_q_depth = 4;   // request queue per destination
  localparam int ord_q_depth = 4;   // issued-but-not-forwarded orders

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [data_w-1:0] data;
    logic              last;
  } beat_t;

endpackage

/* hw/sync_fifo.sv */
// synchronous valid/ready FIFO with a type parameter for request, data and order queues
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic     aclk,
  input  logic     arst_n,
  // write side
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  // read side
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // payload storage
  payload_t mem [depth];

  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth+1)-1:0] count;
  logic push;
  logic pop;
  logic full;

  assign full      = (count == depth);
  // full still takes a push when the head leaves this cycle
  assign in_ready  = !full || out_ready;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // pointers wrap at depth and count tracks occupancy
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a write that is held off keeps its valid and data until taken
  a_in_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    (in_valid && !in_ready) |=> in_valid && $stable(in_data));

endmodule

/* hw/req_route.sv */
// steers incoming write requests into one request queue per destination
`timescale 1ns/1ps

module req_route (
  input  logic                aclk,
  input  logic                arst_n,
  // incoming requests
  input  cred_req_pkg::req_t  s_req,
  input  logic                s_req_valid,
  output logic                s_req_ready,
  // queue heads, one per destination
  output cred_req_pkg::req_t  q_req [cred_req_pkg::n_dests],
  output logic [cred_req_pkg::n_dests-1:0] q_valid,
  input  logic [cred_req_pkg::n_dests-1:0] q_ready
);

  logic [cred_req_pkg::n_dests-1:0] in_ready;

  // ready comes back only from the queue that dest names
  assign s_req_ready = in_ready[s_req.dest];

  for (genvar i = 0; i < cred_req_pkg::n_dests; i++) begin : g_q
    sync_fifo #(
      .payload_t (cred_req_pkg::req_t),
      .depth     (cred_axis_pkg::req_q_depth)
    ) u_req_q (
      .aclk      (aclk),
      .arst_n    (arst_n),
      .in_data   (s_req),
      .in_valid  (s_req_valid && (s_req.dest == i)),   // decoded valid
      .in_ready  (in_ready[i]),
      .out_data  (q_req[i]),
      .out_valid (q_valid[i]),
      .out_ready (q_ready[i])
    );
  end

  // dest in range, len within one data buffer
  a_req_legal: assert property (@(posedge aclk) disable iff (!arst_n)
    s_req_valid |-> (s_req.dest < cred_req_pkg::n_dests) && (s_req.len >= 1)
                    && (s_req.len <= cred_axis_pkg::buf_depth));

endmodule

/* hw/req_credits_wr.sv */
// per-destination credit gate, holds a request until its whole payload is buffered
`timescale 1ns/1ps

module req_credits_wr (
  input  logic               aclk,
  input  logic               arst_n,
  // request from the destination queue
  input  cred_req_pkg::req_t s_req,
  input  logic               s_req_valid,
  output logic               s_req_ready,
  // one pulse per beat accepted into this destination's buffer
  input  logic               xfer,
  // request toward the arbiter
  output cred_req_pkg::req_t m_req,
  output logic               m_req_valid,
  input  logic               m_req_ready
);

  logic [cred_req_pkg::cred_w-1:0] cred;
  logic [cred_req_pkg::cred_w-1:0] len_ext;
  logic [cred_req_pkg::cred_w-1:0] sub;
  logic enough;
  logic handoff;

  // zero-extend len to counter width
  assign len_ext = {{(cred_req_pkg::cred_w - cred_req_pkg::len_w){1'b0}}, s_req.len};
  assign enough  = (cred >= len_ext);

  // purely combinational pass, gated on credit
  assign m_req       = s_req;
  assign m_req_valid = s_req_valid && enough;
  assign s_req_ready = m_req_ready && enough;
  assign handoff     = s_req_valid && s_req_ready;
  assign sub         = handoff ? len_ext : '0;

  // beats in minus beats reserved by released requests
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      cred <= '0;
    end else begin
      cred <= cred + {{(cred_req_pkg::cred_w - 1){1'b0}}, xfer} - sub;
    end
  end

  // unreserved beats can never exceed the buffer behind this gate
  a_cred_bound: assert property (@(posedge aclk) disable iff (!arst_n)
    cred <= cred_axis_pkg::buf_depth);

endmodule

/* hw/dest_req_arb.sv */
// round-robin arbiter that registers the released request on m_req and queues its forwarding order
`timescale 1ns/1ps

module dest_req_arb (
  input  logic                      aclk,
  input  logic                      arst_n,
  // one released request per destination
  input  cred_req_pkg::req_t        s_req [cred_req_pkg::n_dests],
  input  logic [cred_req_pkg::n_dests-1:0] s_valid,
  output logic [cred_req_pkg::n_dests-1:0] s_ready,
  // registered issued request
  output cred_req_pkg::req_t        m_req,
  output logic                      m_req_valid,
  input  logic                      m_req_ready,
  // forwarding order toward the data mux
  output cred_req_pkg::mux_user_t   ord,
  output logic                      ord_valid,
  input  logic                      ord_ready
);

  logic [cred_req_pkg::n_dests-1:0] gnt;
  logic [cred_req_pkg::dest_w-1:0]  gnt_idx;
  logic [cred_req_pkg::dest_w-1:0]  last;
  logic can_issue;
  logic issue;
  logic ord_in_ready;
  cred_req_pkg::mux_user_t ord_in;

  // output register free or draining and room for the order
  assign can_issue = (!m_req_valid || m_req_ready) && ord_in_ready;
  assign s_ready   = gnt & {cred_req_pkg::n_dests{can_issue}};
  assign issue     = (|gnt) && can_issue;

  // search starts one past the last granted destination
  always_comb begin
    int idx;
    gnt     = '0;
    gnt_idx = last;
    for (int k = 1; k <= cred_req_pkg::n_dests; k++) begin
      idx = (int'(last) + k) % cred_req_pkg::n_dests;
      if (s_valid[idx] && (gnt == '0)) begin
        gnt[idx] = 1'b1;
        gnt_idx  = (cred_req_pkg::dest_w)'(idx);
      end
    end
    ord_in.dest = gnt_idx;
    ord_in.len  = s_req[gnt_idx].len;
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_req_valid <= 1'b0;
      last        <= (cred_req_pkg::dest_w)'(cred_req_pkg::n_dests - 1);   // dest 0 first
    end else if (issue) begin
      m_req_valid <= 1'b1;
      last        <= gnt_idx;
    end else if (m_req_ready) begin
      m_req_valid <= 1'b0;
    end
  end

  // request payload
  always_ff @(posedge aclk) begin
    if (issue) begin
      m_req <= s_req[gnt_idx];
    end
  end

  sync_fifo #(
    .payload_t (cred_req_pkg::mux_user_t),
    .depth     (cred_axis_pkg::ord_q_depth)
  ) u_ord_q (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_data   (ord_in),
    .in_valid  (issue),
    .in_ready  (ord_in_ready),
    .out_data  (ord),
    .out_valid (ord_valid),
    .out_ready (ord_ready)
  );

  // with every destination waiting the previous winner is passed over
  a_rr_rotate: assert property (@(posedge aclk) disable iff (!arst_n)
    (issue && (&s_valid)) |-> (gnt_idx != last));

endmodule

/* hw/axis_mux_user_wr.sv */
// forwards len beats from the ordered destination buffer onto the single output stream
`timescale 1ns/1ps

module axis_mux_user_wr (
  input  logic                      aclk,
  input  logic                      arst_n,
  // forwarding order from the arbiter
  input  cred_req_pkg::mux_user_t   ord,
  input  logic                      ord_valid,
  output logic                      ord_ready,
  // destination data buffers
  input  cred_axis_pkg::beat_t      s_axis [cred_req_pkg::n_dests],
  input  logic [cred_req_pkg::n_dests-1:0] s_valid,
  output logic [cred_req_pkg::n_dests-1:0] s_ready,
  // output stream
  output cred_axis_pkg::beat_t      m_axis,
  output logic                      m_axis_valid,
  input  logic                      m_axis_ready
);

  logic                            active;
  logic [cred_req_pkg::len_w-1:0]  cnt;    // beats still to send
  logic [cred_req_pkg::dest_w-1:0] sel;
  logic beat;
  logic fin;

  // selected buffer straight to the output
  always_comb begin
    m_axis.data  = s_axis[sel].data;
    m_axis.last  = (cnt == 1);   // counted, not taken from the source
    s_ready      = '0;
    s_ready[sel] = active && m_axis_ready;
  end

  assign m_axis_valid = active && s_valid[sel];
  assign beat         = m_axis_valid && m_axis_ready;
  assign fin          = beat && m_axis.last;
  // next order loads on the final beat, no bubble between requests
  assign ord_ready    = !active || fin;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      active <= 1'b0;
      cnt    <= '0;
      sel    <= '0;
    end else if (ord_valid && ord_ready) begin
      active <= 1'b1;
      cnt    <= ord.len;
      sel    <= ord.dest;
    end else if (beat) begin
      cnt <= cnt - 1'b1;
      if (fin) begin
        active <= 1'b0;
      end
    end
  end

  // payload framing from the source must match the request length
  a_last_match: assert property (@(posedge aclk) disable iff (!arst_n)
    m_axis_valid |-> (s_axis[sel].last == m_axis.last));

endmodule

/* hw/remote_credits_wr.sv */
// top of the credited write path: route, credit gates, data buffers, arbiter and output mux
`timescale 1ns/1ps

module remote_credits_wr (
  input  logic                      aclk,
  input  logic                      arst_n,
  // write requests in
  input  cred_req_pkg::req_t        s_req,
  input  logic                      s_req_valid,
  output logic                      s_req_ready,
  // payload streams, one per destination
  input  cred_axis_pkg::beat_t      s_axis [cred_req_pkg::n_dests],
  input  logic [cred_req_pkg::n_dests-1:0] s_axis_valid,
  output logic [cred_req_pkg::n_dests-1:0] s_axis_ready,
  // released requests out
  output cred_req_pkg::req_t        m_req,
  output logic                      m_req_valid,
  input  logic                      m_req_ready,
  // forwarded payload
  output cred_axis_pkg::beat_t      m_axis,
  output logic                      m_axis_valid,
  input  logic                      m_axis_ready
);

  cred_req_pkg::req_t   q_req [cred_req_pkg::n_dests];
  cred_req_pkg::req_t   c_req [cred_req_pkg::n_dests];
  cred_axis_pkg::beat_t b_axis [cred_req_pkg::n_dests];
  logic [cred_req_pkg::n_dests-1:0] q_valid, q_ready, c_valid, c_ready;
  logic [cred_req_pkg::n_dests-1:0] b_valid, b_ready;
  cred_req_pkg::mux_user_t ord;
  logic ord_valid, ord_ready;

  req_route u_route (.aclk, .arst_n, .s_req, .s_req_valid, .s_req_ready,
                     .q_req, .q_valid, .q_ready);

  for (genvar i = 0; i < cred_req_pkg::n_dests; i++) begin : g_dest
    req_credits_wr u_cred (.aclk, .arst_n, .s_req(q_req[i]), .s_req_valid(q_valid[i]),
                           .s_req_ready(q_ready[i]), .xfer(s_axis_valid[i] && s_axis_ready[i]),
                           .m_req(c_req[i]), .m_req_valid(c_valid[i]), .m_req_ready(c_ready[i]));

    sync_fifo #(.payload_t(cred_axis_pkg::beat_t), .depth(cred_axis_pkg::buf_depth)) u_buf (
      .aclk, .arst_n, .in_data(s_axis[i]), .in_valid(s_axis_valid[i]), .in_ready(s_axis_ready[i]),
      .out_data(b_axis[i]), .out_valid(b_valid[i]), .out_ready(b_ready[i]));
  end

  dest_req_arb u_arb (.aclk, .arst_n, .s_req(c_req), .s_valid(c_valid), .s_ready(c_ready),
                      .m_req, .m_req_valid, .m_req_ready, .ord, .ord_valid, .ord_ready);

  axis_mux_user_wr u_mux (.aclk, .arst_n, .ord, .ord_valid, .ord_ready, .s_axis(b_axis),
                          .s_valid(b_valid), .s_ready(b_ready), .m_axis, .m_axis_valid,
                          .m_axis_ready);

endmodule

/* include/tb_checks.svh */
// reference queues, typed compares and cycle timeout that the testbench module includes
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  cred_req_pkg::req_t   exp_req_q [$];    // in grant order
  cred_axis_pkg::beat_t exp_beat_q [$];   // payload in the same order
  int unsigned          cycle_cnt = 0;

  // first failure ends the run
  task automatic fail(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  // wrong values are reported with the time
  task automatic mismatch(input string msg);
    fail($sformatf("mismatch at %0t: %s", $time, msg));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compares that each pop the next expected item
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic cmp_req(input cred_req_pkg::req_t got);
    cred_req_pkg::req_t exp;
    if (exp_req_q.size() == 0) begin
      fail($sformatf("request %h arrived while none was expected", got));
    end else begin
      exp = exp_req_q.pop_front();
      if (got !== exp) mismatch($sformatf("request got %h expected %h", got, exp));
    end
  endtask

  task automatic cmp_beat(input cred_axis_pkg::beat_t got);
    cred_axis_pkg::beat_t exp;
    if (exp_beat_q.size() == 0) begin
      fail($sformatf("beat %h arrived while none was expected", got));
    end else begin
      exp = exp_beat_q.pop_front();
      if (got !== exp) mismatch($sformatf("beat got %h expected %h", got, exp));
    end
  endtask

  // called once per cycle by the testbench clock loop
  task automatic check_timeout(input int unsigned limit = 2000);
    cycle_cnt++;
    if (cycle_cnt > limit) fail("timeout because the design stopped making progress");
  endtask

`endif

/* tb/tb_remote_credits_wr.sv */
// testbench that runs directed self-checking tests on the credited write path of remote_credits_wr
`timescale 1ns/1ps

module tb_remote_credits_wr;

  // roughly 10 + 40 + 60 + 60 + 800 cycles of tests with wide margin
  localparam int unsigned timeout_cycles = 2000;

  logic                      aclk;
  logic                      arst_n;
  cred_req_pkg::req_t        s_req;
  logic                      s_req_valid;
  logic                      s_req_ready;
  cred_axis_pkg::beat_t      s_axis [cred_req_pkg::n_dests];
  logic [cred_req_pkg::n_dests-1:0] s_axis_valid;
  logic [cred_req_pkg::n_dests-1:0] s_axis_ready;
  cred_req_pkg::req_t        m_req;
  logic                      m_req_valid;
  logic                      m_req_ready;
  cred_axis_pkg::beat_t      m_axis;
  logic                      m_axis_valid;
  logic                      m_axis_ready;

  `include "tb_checks.svh"

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus and per-destination reference state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  int                   seed;
  logic [7:0]           tag_next = 8'h10;
  logic                 by_dest = 1'b0;   // grant order left to the arbiter
  logic                 seen = 1'b0;      // current m_req already moved to exp queues
  logic                 rnd_done;
  int                   mon_d;
  cred_req_pkg::req_t   mon_r;
  cred_req_pkg::req_t   req_stim_q [$];
  cred_axis_pkg::beat_t stim_q [cred_req_pkg::n_dests][$];
  cred_req_pkg::req_t   ref_req [cred_req_pkg::n_dests][$];
  cred_axis_pkg::beat_t ref_beat [cred_req_pkg::n_dests][$];

  remote_credits_wr dut0 (.aclk, .arst_n, .s_req, .s_req_valid, .s_req_ready, .s_axis,
                          .s_axis_valid, .s_axis_ready, .m_req, .m_req_valid, .m_req_ready,
                          .m_axis, .m_axis_valid, .m_axis_ready);

  initial begin
    aclk = 1'b0;
    forever begin
      #5;
      aclk = 1'b1;
      check_timeout(timeout_cycles);
      #5;
      aclk = 1'b0;
    end
  end

  // builds one request and its payload and files the expected items directly or per destination
  task automatic add_req(input int d, input int len);
    cred_req_pkg::req_t   r;
    cred_axis_pkg::beat_t b;
    r.dest   = (cred_req_pkg::dest_w)'(d);
    r.len    = (cred_req_pkg::len_w)'(len);
    r.tag    = tag_next;
    tag_next = tag_next + 8'd1;
    req_stim_q.push_back(r);
    if (by_dest) ref_req[d].push_back(r);
    else exp_req_q.push_back(r);
    for (int k = 0; k < len; k++) begin
      b.data = {$random(seed), $random(seed)};
      b.last = (k == len - 1);   // source framing matches len
      stim_q[d].push_back(b);
      if (by_dest) ref_beat[d].push_back(b);
      else exp_beat_q.push_back(b);
    end
  endtask

  task automatic drive_req();
    @(negedge aclk);
    s_req       = req_stim_q.pop_front();
    s_req_valid = 1'b1;
    do @(posedge aclk); while (!s_req_ready);
    @(negedge aclk);
    s_req_valid = 1'b0;
  endtask

  task automatic drive_beats(input int d, input int n);
    repeat (n) begin
      @(negedge aclk);
      s_axis[d]       = stim_q[d].pop_front();
      s_axis_valid[d] = 1'b1;
      do @(posedge aclk); while (!s_axis_ready[d]);
      @(negedge aclk);
      s_axis_valid[d] = 1'b0;
    end
  endtask

  function automatic int pending();
    int n;
    n = exp_req_q.size() + exp_beat_q.size();
    for (int i = 0; i < cred_req_pkg::n_dests; i++) n += ref_req[i].size() + ref_beat[i].size();
    return n;
  endfunction

  task automatic wait_drained();
    while (pending() != 0) @(posedge aclk);
  endtask

  // output monitor sampled on the rising edge before any update
  always @(posedge aclk) begin
    if (arst_n) begin
      // a newly issued request fixes where its payload sits in the output order
      if (by_dest && m_req_valid && !seen) begin
        mon_d = int'(m_req.dest);
        if (ref_req[mon_d].size() == 0) begin
          fail("request issued for a destination with nothing pending");
        end else begin
          mon_r = ref_req[mon_d].pop_front();
          exp_req_q.push_back(mon_r);
          repeat (mon_r.len) exp_beat_q.push_back(ref_beat[mon_d].pop_front());
          seen = 1'b1;
        end
      end
      if (m_req_valid && m_req_ready) begin
        cmp_req(m_req);
        seen = 1'b0;
      end
      if (m_axis_valid && m_axis_ready) cmp_beat(m_axis);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic idle_after_reset();
    repeat (10) begin
      @(posedge aclk);
      if (m_req_valid !== 1'b0 || m_axis_valid !== 1'b0) begin
        fail("output valid raised with no input");
      end
    end
  endtask

  task automatic data_before_request();
    add_req(0, 4);
    drive_beats(0, 4);
    drive_req();
    wait_drained();
  endtask

  // with 7 of 8 beats buffered the request waits for the last one
  // m_req_ready stays low so an early release would hold m_req_valid high
  task automatic credit_hold();
    @(negedge aclk);
    m_req_ready = 1'b0;
    add_req(1, 8);
    drive_req();
    drive_beats(1, 7);
    repeat (20) begin
      @(posedge aclk);
      if (m_req_valid !== 1'b0) fail("request released before its payload was buffered");
    end
    @(negedge aclk);
    m_req_ready = 1'b1;
    drive_beats(1, 1);
    wait_drained();
  endtask

  // last grant went to dest 1, so dest 0 leads
  task automatic round_robin_order();
    @(negedge aclk);
    m_req_ready = 1'b0;
    add_req(0, 3);
    add_req(1, 4);
    add_req(0, 5);
    add_req(1, 2);
    fork
      drive_beats(0, 8);
      drive_beats(1, 6);
    join
    repeat (4) drive_req();
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    m_req_ready = 1'b1;
    wait_drained();
  endtask

  task automatic random_backpressure();
    int n0;
    int n1;
    int rnd;
    by_dest  = 1'b1;
    rnd_done = 1'b0;
    repeat (20) add_req($unsigned($random(seed)) % 2, ($unsigned($random(seed)) % 16) + 1);
    n0 = stim_q[0].size();
    n1 = stim_q[1].size();
    fork
      begin
        fork
          repeat (20) drive_req();
          drive_beats(0, n0);
          drive_beats(1, n1);
        join
        wait_drained();
        rnd_done = 1'b1;
      end
      while (!rnd_done) begin
        @(negedge aclk);
        rnd          = $random(seed);
        m_req_ready  = rnd[0];
        m_axis_ready = rnd[1];
      end
    join
    @(negedge aclk);
    m_req_ready  = 1'b1;
    m_axis_ready = 1'b1;
    by_dest      = 1'b0;
  endtask

  initial begin
    seed         = 32'h1341_302c;
    arst_n       = 1'b0;
    s_req        = '0;
    s_req_valid  = 1'b0;
    s_axis[0]    = '0;
    s_axis[1]    = '0;
    s_axis_valid = '0;
    m_req_ready  = 1'b1;
    m_axis_ready = 1'b1;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    arst_n = 1'b1;
    idle_after_reset();
    data_before_request();
    credit_hold();
    round_robin_order();
    random_backpressure();
    $display("all tests passed");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
hw/cred_req_pkg.sv
hw/cred_axis_pkg.sv
hw/sync_fifo.sv
hw/req_route.sv
hw/req_credits_wr.sv
hw/dest_req_arb.sv
hw/axis_mux_user_wr.sv
hw/remote_credits_wr.sv
tb/tb_remote_credits_wr.sv

/* Bender.yml */
package:
  name: remote_credits_wr

sources:
  - hw/cred_req_pkg.sv
  - hw/cred_axis_pkg.sv
  - hw/sync_fifo.sv
  - hw/req_route.sv
  - hw/req_credits_wr.sv
  - hw/dest_req_arb.sv
  - hw/axis_mux_user_wr.sv
  - hw/remote_credits_wr.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_remote_credits_wr.sv
